//--- sim.f
fod_pkg.sv
dtc_lut_if.sv
mash1_dsm.sv
fod_word_gen.sv
dtc_word_calc.sv
dtc_lut_cal.sv
fod_ctrl_top.sv
fod_checker.sv
tb_fod_ctrl.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tb_fod_ctrl
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_fod_ctrl.sv
`timescale 1ns/1ns

// testbench top, LCG stimulus on the falling edge
module tb_fod_ctrl import fod_pkg::*; ();

	localparam int ERR_LAT = 5;

	logic                 CLK;
	logic                 NARST;
	logic                 DSM_EN;
	logic [FCW_W-1:0]     FCW;
	logic                 RT_EN;
	logic [1:0]           PSEG;
	logic                 GAC_EN;
	logic                 OFSTC_EN;
	logic [1:0]           CALIORDER;
	logic [4:0]           KB;
	logic [4:0]           KC;
	logic [4:0]           KD;
	logic [DCW_W-1:0]     KDTCB_INIT;
	logic [DCW_W-1:0]     KDTCC_INIT;
	logic [DCW_W-1:0]     KDTCD_INIT;
	logic signed [WF-1:0] PHE_ERR;
	logic [WI-1:0]        MMD_DCW;
	logic                 RT_DCW;
	logic [DCW_W-1:0]     DTC_DCW;
	logic                 win_go;
	logic                 win_done;
	int                   err_cnt;
	int                   cmp_cnt;

	logic [31:0] seed;
	int          tests;
	int          fails;
	int          err_mark;
	logic        hung;

	fod_ctrl_top #(.ERR_LAT(ERR_LAT)) i_fod_ctrl_top (.*);

	// reference model and compare
	fod_checker #(.ERR_LAT(ERR_LAT)) i_fod_checker (.*);

	// 10 ns clock
	initial CLK = 1'b0;
	always #5 CLK = ~CLK;

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// upper half of the generator word, low bits are weak
	function automatic logic [15:0] next_rand();
		seed = lcg(seed);
		return seed[31:16];
	endfunction

	// shift codes from -16 up to +2
	function automatic logic [4:0] rand_code();
		int k;
		k = int'(next_rand() % 19) - 16;
		return 5'(k);
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge CLK);
	endtask

	task automatic apply_reset();
		NARST <= 1'b0;
		wait_cycles(16);
		NARST <= 1'b1;
		wait_cycles(5);
	endtask

	task automatic draw_inits();
		KDTCB_INIT <= DCW_W'(next_rand());
		KDTCC_INIT <= DCW_W'(next_rand());
		KDTCD_INIT <= DCW_W'(next_rand());
		wait_cycles(1);
	endtask

	// checker counts settle at the falling edge, read them on the rising one
	task automatic end_test(input string name);
		int n;
		@(posedge CLK);
		n = err_cnt - err_mark;
		err_mark = err_cnt;
		tests++;
		if (n != 0 || hung) begin
			fails++;
		end
		$display("[test %0d] %s: %s, %0d mismatches", tests, name,
			(n == 0 && !hung) ? "ok" : "FAILED", n);
		@(negedge CLK);
	endtask

	task automatic run_density_window();
		int n;
		win_go <= 1'b1;
		n = 0;
		while (!win_done && n < 70000) begin
			@(posedge CLK);
			n++;
		end
		if (!win_done) begin
			$display("timeout: carry density window did not complete");
			hung = 1'b1;
		end
		@(negedge CLK);
		win_go <= 1'b0;
	endtask

	initial begin
		seed = 32'd92;
		tests = 0;
		fails = 0;
		err_mark = 0;
		hung = 1'b0;
		NARST = 1'b0;
		DSM_EN = 1'b0;
		FCW = FCW_W'(MMD_RESET) << WF;
		RT_EN = 1'b0;
		PSEG = 2'd0;
		GAC_EN = 1'b0;
		OFSTC_EN = 1'b0;
		CALIORDER = 2'd0;
		KB = 5'h10;
		KC = 5'h10;
		KD = 5'h10;
		KDTCB_INIT = DCW_W'(next_rand());
		KDTCC_INIT = DCW_W'(next_rand());
		KDTCD_INIT = DCW_W'(next_rand());
		PHE_ERR = '0;
		win_go = 1'b0;

		// ------------------------------
		// reset and carry density
		// ------------------------------
		apply_reset();
		wait_cycles(20);
		end_test("reset values");

		FCW <= FCW_W'({next_rand(), next_rand()});
		DSM_EN <= 1'b1;
		wait_cycles(8);
		run_density_window();
		if (!hung) begin
			// freeze with a live fraction, carry and phase must hold
			DSM_EN <= 1'b0;
			wait_cycles(12);
			// zero fraction clears the carry before the next freeze
			FCW[WF-1:0] <= '0;
			DSM_EN <= 1'b1;
			wait_cycles(4);
			DSM_EN <= 1'b0;
			wait_cycles(12);
		end
		end_test("carry density");

		if (!hung) begin
			// ------------------------------
			// retimer, static and calibrated DTC word
			// ------------------------------
			for (int ph = 0; ph < 8; ph++) begin
				RT_EN <= 1'(next_rand());
				PSEG <= 2'(next_rand());
				FCW <= FCW_W'({next_rand(), next_rand()});
				DSM_EN <= 1'b1;
				wait_cycles(200);
			end
			end_test("retimer select");

			for (int r = 0; r < 4; r++) begin
				draw_inits();
				apply_reset();
				RT_EN <= 1'(next_rand());
				PSEG <= 2'(next_rand());
				FCW <= FCW_W'({next_rand(), next_rand()});
				DSM_EN <= 1'b1;
				wait_cycles(400);
			end
			end_test("static DTC word");

			GAC_EN <= 1'b1;
			OFSTC_EN <= 1'b1;
			KB <= rand_code();
			KC <= rand_code();
			KD <= rand_code();
			PSEG <= 2'(next_rand());
			for (int c = 0; c < 4000; c++) begin
				// retimer on for the first half so its table learns
				if (c % 1000 == 0) begin
					CALIORDER <= 2'(next_rand());
					RT_EN <= (c < 2000) ? 1'b1 : 1'(next_rand());
				end
				PHE_ERR <= next_rand();
				wait_cycles(1);
			end
			GAC_EN <= 1'b0;
			OFSTC_EN <= 1'b0;
			wait_cycles(10);
			end_test("calibration");
		end

		$display("tests %0d, failed %0d, compares %0d, mismatches %0d",
			tests, fails, cmp_cnt, err_cnt);
		if (fails == 0 && err_cnt == 0 && cmp_cnt > 0 && !hung) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- fod_checker.sv
`timescale 1ns/1ns

// cycle model of the divider control, compared with the DUT outputs
module fod_checker import fod_pkg::*; #(
	parameter int ERR_LAT = 5
) (
	input  logic                 CLK,
	input  logic                 NARST,
	input  logic                 DSM_EN,
	input  logic [FCW_W-1:0]     FCW,
	input  logic                 RT_EN,
	input  logic [1:0]           PSEG,
	input  logic                 GAC_EN,
	input  logic                 OFSTC_EN,
	input  logic [1:0]           CALIORDER,
	input  logic [4:0]           KB,
	input  logic [4:0]           KC,
	input  logic [4:0]           KD,
	input  logic [DCW_W-1:0]     KDTCB_INIT,
	input  logic [DCW_W-1:0]     KDTCC_INIT,
	input  logic [DCW_W-1:0]     KDTCD_INIT,
	input  logic signed [WF-1:0] PHE_ERR,
	input  logic [WI-1:0]        MMD_DCW,
	input  logic                 RT_DCW,
	input  logic [DCW_W-1:0]     DTC_DCW,
	input  logic                 win_go,
	output logic                 win_done,
	output int                   err_cnt,
	output int                   cmp_cnt
);

	// model state
	logic [2:0]              rs;
	logic                    seen_rst;
	logic [FCW_W-1:0]        fq;
	logic [WF-1:0]           acc;
	logic                    cy;
	logic [WI-1:0]           m1;
	logic [WI-1:0]           m2;
	logic [WI-1:0]           m3;
	logic [2:0]              s_idx;
	logic [WF-1:0]           s_frac;
	logic                    s_q;
	logic                    rt2;
	logic                    rt3;
	longint                  term_q;
	longint                  oc_q;
	longint                  od_q;
	logic [DCW_W-1:0]        dtc_m;
	logic signed [LUT_W-1:0] gain_t [N_SEG];
	logic signed [LUT_W-1:0] off_t [N_SEG];
	logic signed [LUT_W-1:0] rt_t [2];
	// segment records seen by the phase detector, newest at the front
	logic [19:0]             hist [$];
	int                      win_n;
	longint                  win_sum;

	initial begin
		seen_rst = 1'b0;
		win_done = 1'b0;
		err_cnt = 0;
		cmp_cnt = 0;
		win_n = 0;
		win_sum = 0;
	end

	// signed 5-bit code, negative is a right shift
	function automatic longint code_shift(input longint v, input logic [4:0] k);
		int n;
		n = $signed(k);
		if (n < 0) begin
			return v >>> (-n);
		end
		return v <<< n;
	endfunction

	// round half up to the 10-bit word, wraps
	function automatic logic [DCW_W-1:0] round_word(input longint s);
		longint r;
		r = (s + (longint'(1) <<< (WF - 1))) >>> WF;
		return DCW_W'(r);
	endfunction

	task automatic compare(input string name, input longint exp, input longint act);
		cmp_cnt++;
		if (exp != act) begin
			err_cnt++;
			$display("[ERROR] t=%0t %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	// ------------------------------
	// reset state
	// ------------------------------
	task automatic load_reset();
		fq = FCW_W'(MMD_RESET) << WF;
		acc = '0;
		cy = 1'b0;
		m1 = MMD_RESET;
		m2 = MMD_RESET;
		m3 = MMD_RESET;
		s_idx = '0;
		s_frac = '0;
		s_q = 1'b0;
		rt2 = 1'b0;
		rt3 = 1'b0;
		term_q = 0;
		oc_q = 0;
		od_q = 0;
		dtc_m = '0;
		// init codes scaled by 2^WF, offsets grow with the index
		for (int i = 0; i < N_SEG; i++) begin
			gain_t[i] = longint'(KDTCB_INIT) <<< WF;
			off_t[i] = (longint'(KDTCC_INIT) * i) <<< WF;
		end
		rt_t[0] = longint'(KDTCD_INIT) <<< WF;
		rt_t[1] = longint'(KDTCD_INIT) <<< WF;
		hist.delete();
		repeat (ERR_LAT) hist.push_back('0);
	endtask

	// ------------------------------
	// one clock of the model
	// ------------------------------
	// stages from output back to input, each reads last cycle's values
	task automatic advance();
		logic [WF-1:0] rem;
		logic [2:0]    r_idx;
		logic [WF-1:0] r_frac;
		logic          r_q;
		longint        err;
		dtc_m = round_word(term_q + oc_q + od_q);
		// gain times fraction, back to WF fraction bits
		term_q = (longint'(gain_t[s_idx]) * longint'(s_frac)) >>> WF;
		oc_q = off_t[s_idx];
		od_q = s_q ? longint'(rt_t[1]) : 0;
		// record from ERR_LAT cycles back meets the current error
		{r_idx, r_frac, r_q} = hist.pop_back();
		hist.push_front({s_idx, s_frac, s_q});
		err = PHE_ERR;
		if (GAC_EN && CALIORDER[1]) begin
			gain_t[r_idx] = gain_t[r_idx] + code_shift((err * longint'(r_frac)) >>> WF, KB);
		end
		if (GAC_EN && CALIORDER[0]) begin
			if (r_idx == 0) begin
				off_t[0] = '0;
			end else begin
				off_t[r_idx] = off_t[r_idx] + code_shift(err, KC);
			end
		end
		if (OFSTC_EN && r_q) begin
			rt_t[1] = rt_t[1] + code_shift(err, KD);
		end
		rt3 = rt2;
		rt2 = s_q;
		m3 = m2;
		m2 = m1;
		m1 = fq[FCW_W-1:WF] + cy;
		// half-cycle split when the retimer is on
		rem = RT_EN ? {acc[WF-2:0], 1'b0} : acc;
		s_q = RT_EN & acc[WF-1];
		s_idx = rem[WF-1:WF-3] >> PSEG;
		s_frac = rem % (32'd1 << (WF - 3 + PSEG));
		if (DSM_EN) begin
			{cy, acc} = acc + fq[WF-1:0];
		end
		fq = FCW;
	endtask

	// synchroniser holds the model in reset three clocks past NARST
	always @(posedge CLK or negedge NARST) begin
		if (!NARST) begin
			rs = '0;
			seen_rst = 1'b1;
			load_reset();
		end else if (!rs[2]) begin
			rs = {rs[1:0], 1'b1};
			load_reset();
		end else begin
			advance();
		end
	end

	// outputs are stable on the falling edge
	always @(negedge CLK) begin
		if (seen_rst && NARST) begin
			compare("MMD_DCW", m3, MMD_DCW);
			compare("RT_DCW", rt3, RT_DCW);
			compare("DTC_DCW", dtc_m, DTC_DCW);
		end
		// carry count over one full accumulator period
		if (!win_go) begin
			win_n = 0;
			win_sum = 0;
			win_done = 1'b0;
		end else if (!win_done) begin
			win_sum += WI'(MMD_DCW - FCW[FCW_W-1:WF]);
			win_n++;
			if (win_n == (1 << WF)) begin
				compare("MMD_DCW carry sum", FCW[WF-1:0], win_sum);
				win_done = 1'b1;
			end
		end
	end

endmodule

//--- fod_ctrl_top.sv
`timescale 1ns/1ns

// fractional output divider control, top level
module fod_ctrl_top import fod_pkg::*; #(
	parameter int ERR_LAT = 5
) (
	input  logic                 CLK,
	input  logic                 NARST,
	input  logic                 DSM_EN,
	input  logic [FCW_W-1:0]     FCW,
	input  logic                 RT_EN,
	input  logic [1:0]           PSEG,
	input  logic                 GAC_EN,
	input  logic                 OFSTC_EN,
	input  logic [1:0]           CALIORDER,
	input  logic [4:0]           KB,
	input  logic [4:0]           KC,
	input  logic [4:0]           KD,
	input  logic [DCW_W-1:0]     KDTCB_INIT,
	input  logic [DCW_W-1:0]     KDTCC_INIT,
	input  logic [DCW_W-1:0]     KDTCD_INIT,
	input  logic signed [WF-1:0] PHE_ERR,
	output logic [WI-1:0]        MMD_DCW,
	output logic                 RT_DCW,
	output logic [DCW_W-1:0]     DTC_DCW
);

	logic [2:0]    rst_sync;
	logic          NRST;
	logic [WF-1:0] dsm_frac;
	logic          dsm_carry;
	dsm_phe_u      dsm_phe;
	seg_idx_t      seg_idx;
	logic [WF-1:0] seg_frac;
	logic          seg_quant;

	dtc_lut_if lut_bus ();

	// ------------------------------
	// reset synchroniser
	// ------------------------------
	// async assert, release after three clocks
	always_ff @(posedge CLK or negedge NARST) begin
		if (!NARST) begin
			rst_sync <= '0;
		end else begin
			rst_sync <= {rst_sync[1:0], 1'b1};
		end
	end

	assign NRST = rst_sync[2];

	// ------------------------------
	// datapath
	// ------------------------------
	mash1_dsm i_mash1_dsm (
		.CLK   (CLK),
		.NRST  (NRST),
		.en    (DSM_EN),
		.frac  (dsm_frac),
		.carry (dsm_carry),
		.phe   (dsm_phe)
	);

	fod_word_gen i_fod_word_gen (
		.CLK      (CLK),
		.NRST     (NRST),
		.fcw      (FCW),
		.carry    (dsm_carry),
		.phe      (dsm_phe),
		.rt_en    (RT_EN),
		.pseg     (PSEG),
		.frac     (dsm_frac),
		.mmd_dcw  (MMD_DCW),
		.rt_dcw   (RT_DCW),
		.seg_idx  (seg_idx),
		.seg_frac (seg_frac),
		.quant    (seg_quant)
	);

	dtc_word_calc i_dtc_word_calc (
		.CLK      (CLK),
		.NRST     (NRST),
		.seg_idx  (seg_idx),
		.seg_frac (seg_frac),
		.quant    (seg_quant),
		.lut      (lut_bus.word_calc),
		.dtc_dcw  (DTC_DCW)
	);

	// calibrated tables
	dtc_lut_cal #(
		.ERR_LAT (ERR_LAT)
	) i_dtc_lut_cal (
		.CLK        (CLK),
		.NRST       (NRST),
		.seg_frac   (seg_frac),
		.phe_err    (PHE_ERR),
		.gac_en     (GAC_EN),
		.ofstc_en   (OFSTC_EN),
		.caliorder  (CALIORDER),
		.kb         (KB),
		.kc         (KC),
		.kd         (KD),
		.kdtcb_init (KDTCB_INIT),
		.kdtcc_init (KDTCC_INIT),
		.kdtcd_init (KDTCD_INIT),
		.lut        (lut_bus.lut)
	);

endmodule

//--- dtc_lut_cal.sv
`timescale 1ns/1ns

// piecewise gain, offset and retimer tables with sign-LMS update
module dtc_lut_cal import fod_pkg::*; #(
	parameter int ERR_LAT = 5
) (
	input  logic                 CLK,
	input  logic                 NRST,
	input  logic [WF-1:0]        seg_frac,
	input  logic signed [WF-1:0] phe_err,
	input  logic                 gac_en,
	input  logic                 ofstc_en,
	input  logic [1:0]           caliorder,
	input  logic [4:0]           kb,
	input  logic [4:0]           kc,
	input  logic [4:0]           kd,
	input  logic [DCW_W-1:0]     kdtcb_init,
	input  logic [DCW_W-1:0]     kdtcc_init,
	input  logic [DCW_W-1:0]     kdtcd_init,
	dtc_lut_if.lut               lut
);

	logic signed [LUT_W-1:0] lut_b [N_SEG];
	logic signed [LUT_W-1:0] lut_c [N_SEG];
	logic signed [LUT_W-1:0] lut_d [2];

	// segment record delay line, models the phase detector latency
	seg_idx_t                idx_dl [ERR_LAT];
	logic [WF-1:0]           frac_dl [ERR_LAT];
	logic                    quant_dl [ERR_LAT];

	seg_idx_t                rec_idx;
	logic [WF-1:0]           rec_frac;
	logic                    rec_quant;
	logic signed [LUT_W-1:0] err_ext;
	logic signed [2*WF:0]    err_frac;
	logic signed [LUT_W-1:0] step_b;
	logic signed [LUT_W-1:0] step_c;
	logic signed [LUT_W-1:0] step_d;

	// signed shift code, negative is arithmetic right by the magnitude
	function automatic logic signed [LUT_W-1:0] sshift(
		input logic signed [LUT_W-1:0] v,
		input logic [4:0]              k
	);
		logic [4:0] mag;
		mag = ~k + 5'd1;
		if (k[4]) begin
			return v >>> mag;
		end
		return v <<< k;
	endfunction

	// ------------------------------
	// table read
	// ------------------------------
	assign lut.gain_b = lut_b[lut.seg_idx];
	assign lut.offset_c = lut_c[lut.seg_idx];
	assign lut.offset_d = lut_d[lut.quant];

	// record delay, ERR_LAT stages
	always_ff @(posedge CLK or negedge NRST) begin
		if (!NRST) begin
			for (int i = 0; i < ERR_LAT; i++) begin
				idx_dl[i] <= '0;
				frac_dl[i] <= '0;
				quant_dl[i] <= 1'b0;
			end
		end else begin
			idx_dl[0] <= lut.seg_idx;
			frac_dl[0] <= seg_frac;
			quant_dl[0] <= lut.quant;
			for (int i = 1; i < ERR_LAT; i++) begin
				idx_dl[i] <= idx_dl[i-1];
				frac_dl[i] <= frac_dl[i-1];
				quant_dl[i] <= quant_dl[i-1];
			end
		end
	end

	assign rec_idx = idx_dl[ERR_LAT-1];
	assign rec_frac = frac_dl[ERR_LAT-1];
	assign rec_quant = quant_dl[ERR_LAT-1];

	// ------------------------------
	// LMS steps
	// ------------------------------
	always_comb begin
		err_ext = LUT_W'(phe_err);
		// error times fraction, back to WF fraction bits
		err_frac = phe_err * $signed({1'b0, rec_frac});
		step_b = sshift(LUT_W'(err_frac >>> WF), kb);
		step_c = sshift(err_ext, kc);
		step_d = sshift(err_ext, kd);
	end

	// tables load from the init codes on reset, all updates on one edge
	always_ff @(posedge CLK or negedge NRST) begin
		if (!NRST) begin
			for (int i = 0; i < N_SEG; i++) begin
				lut_b[i] <= {1'b0, kdtcb_init, {WF{1'b0}}};
				// segment start grows linearly with index
				lut_c[i] <= LUT_W'(kdtcc_init * i) << WF;
			end
			lut_d[0] <= {1'b0, kdtcd_init, {WF{1'b0}}};
			lut_d[1] <= {1'b0, kdtcd_init, {WF{1'b0}}};
		end else begin
			// first-order term, gain per segment
			if (gac_en && caliorder[1]) begin
				lut_b[rec_idx] <= lut_b[rec_idx] + step_b;
			end
			// zeroth-order term, segment 0 is the reference point
			if (gac_en && caliorder[0]) begin
				lut_c[rec_idx] <= (rec_idx == '0) ? '0 : lut_c[rec_idx] + step_c;
			end
			// retimer offset learns only from late half cycles
			if (ofstc_en && rec_quant) begin
				lut_d[1] <= lut_d[1] + step_d;
			end
		end
	end

endmodule

//--- dtc_word_calc.sv
`timescale 1ns/1ns

// DTC word from gain, segment offset and retimer offset
module dtc_word_calc import fod_pkg::*; (
	input  logic                CLK,
	input  logic                NRST,
	input  seg_idx_t            seg_idx,
	input  logic [WF-1:0]       seg_frac,
	input  logic                quant,
	dtc_lut_if.word_calc        lut,
	output logic [DCW_W-1:0]    dtc_dcw
);

	// fraction split into two halves for the multiply
	localparam int HALF = WF / 2;
	// partial product width, signed gain times unsigned half
	localparam int PP_W = LUT_W + HALF + 1;
	// full product width
	localparam int PROD_W = LUT_W + WF + 1;

	logic signed [PP_W-1:0]    pp_hi;
	logic signed [PP_W-1:0]    pp_lo;
	logic signed [LUT_W-1:0]   off_c_q;
	logic signed [LUT_W-1:0]   off_d_q;
	logic signed [PROD_W-1:0]  prod_full;
	logic signed [LUT_W-1:0]   term_b;
	logic signed [LUT_W+1:0]   dcw_sum;
	logic [DCW_W-1:0]          dcw_rnd;

	// table address straight from the segment register
	assign lut.seg_idx = seg_idx;
	assign lut.quant = quant;

	// ------------------------------
	// multiply stage 1
	// ------------------------------
	// partial products, offsets follow alongside
	always_ff @(posedge CLK or negedge NRST) begin
		if (!NRST) begin
			pp_hi <= '0;
			pp_lo <= '0;
			off_c_q <= '0;
			off_d_q <= '0;
		end else begin
			pp_hi <= lut.gain_b * $signed({1'b0, seg_frac[WF-1:HALF]});
			pp_lo <= lut.gain_b * $signed({1'b0, seg_frac[HALF-1:0]});
			off_c_q <= lut.offset_c;
			// retimer term only in the late half cycle
			off_d_q <= quant ? lut.offset_d : '0;
		end
	end

	// ------------------------------
	// multiply stage 2 and sum
	// ------------------------------
	always_comb begin
		// recombine the halves
		prod_full = (PROD_W'(pp_hi) <<< HALF) + PROD_W'(pp_lo);
		// drop the fraction's own WF bits
		term_b = prod_full[WF +: LUT_W];
		// gain term + segment start + retimer offset
		dcw_sum = (LUT_W+2)'(term_b) + (LUT_W+2)'(off_c_q) + (LUT_W+2)'(off_d_q);
		// round half up on the first dropped bit
		dcw_rnd = dcw_sum[WF +: DCW_W] + DCW_W'(dcw_sum[WF-1]);
	end

	// output register
	always_ff @(posedge CLK or negedge NRST) begin
		if (!NRST) begin
			dtc_dcw <= '0;
		end else begin
			dtc_dcw <= dcw_rnd;
		end
	end

endmodule

//--- fod_word_gen.sv
`timescale 1ns/1ns

// FCW register, divider and retimer words, segment decode
module fod_word_gen import fod_pkg::*; (
	input  logic             CLK,
	input  logic             NRST,
	input  logic [FCW_W-1:0] fcw,
	input  logic             carry,
	input  dsm_phe_u         phe,
	input  logic             rt_en,
	input  logic [1:0]       pseg,
	output logic [WF-1:0]    frac,
	output logic [WI-1:0]    mmd_dcw,
	output logic             rt_dcw,
	output seg_idx_t         seg_idx,
	output logic [WF-1:0]    seg_frac,
	output logic             quant
);

	logic [FCW_W-1:0] fcw_q;
	logic [WI-1:0]    fcw_int;
	logic [WI-1:0]    mmd_d1;
	logic [WI-1:0]    mmd_d2;
	logic             rt_d2;
	logic             quant_d;
	logic [WF-1:0]    rem_sl;
	logic [WF-1:0]    seg_mask;
	seg_idx_t         seg_idx_d;

	// input FCW register, integer part starts at the reset modulus
	always_ff @(posedge CLK or negedge NRST) begin
		if (!NRST) begin
			fcw_q <= {MMD_RESET, {WF{1'b0}}};
		end else begin
			fcw_q <= fcw;
		end
	end

	// integer to the divider, fraction to the DSM
	assign {fcw_int, frac} = fcw_q;

	// ------------------------------
	// phase decode
	// ------------------------------
	always_comb begin
		if (rt_en) begin
			// MSB picks the half cycle
			quant_d = phe.rt.quant;
			// remainder is below one half, doubled back to full scale
			rem_sl = {phe.rt.rem, 1'b0};
		end else begin
			quant_d = 1'b0;
			rem_sl = phe.frac;
		end
		// fewer segments for larger pseg
		seg_idx_d = rem_sl[WF-1 -: 3] >> pseg;
		// keep only the bits below the index
		seg_mask = {WF{1'b1}} >> (2'd3 - pseg);
	end

	// ------------------------------
	// alignment pipeline
	// ------------------------------
	// three edges from DSM output to every word
	always_ff @(posedge CLK or negedge NRST) begin
		if (!NRST) begin
			mmd_d1 <= MMD_RESET;
			mmd_d2 <= MMD_RESET;
			mmd_dcw <= MMD_RESET;
			seg_idx <= '0;
			seg_frac <= '0;
			quant <= 1'b0;
			rt_d2 <= 1'b0;
			rt_dcw <= 1'b0;
		end else begin
			mmd_d1 <= fcw_int + WI'(carry);
			mmd_d2 <= mmd_d1;
			mmd_dcw <= mmd_d2;
			// segment register, first DTC stage
			seg_idx <= seg_idx_d;
			seg_frac <= rem_sl & seg_mask;
			quant <= quant_d;
			// registered quant is also the first retimer stage
			rt_d2 <= quant;
			rt_dcw <= rt_d2;
		end
	end

endmodule

//--- mash1_dsm.sv
`timescale 1ns/1ns

// first-order delta-sigma modulator
// the registered residual phase doubles as the accumulator state
module mash1_dsm import fod_pkg::*; (
	input  logic          CLK,
	input  logic          NRST,
	input  logic          en,
	input  logic [WF-1:0] frac,
	output logic          carry,
	output dsm_phe_u      phe
);

	// one extra bit to catch the overflow
	logic [WF:0] sum;

	// ------------------------------
	// accumulate
	// ------------------------------

	// wrap modulo 2^WF, top bit is the carry
	assign sum = {1'b0, phe.frac} + {1'b0, frac};

	// carry and residual phase registered together
	// en low holds both outputs and the accumulator
	always_ff @(posedge CLK or negedge NRST) begin
		if (!NRST) begin
			carry <= 1'b0;
			phe <= '0;
		end else if (en) begin
			// overflow bumps the divider by one
			carry <= sum[WF];
			// wrapped sum is the phase residue
			phe.frac <= sum[WF-1:0];
		end
	end

endmodule

//--- dtc_lut_if.sv
`timescale 1ns/1ns

// lookup bus between the DTC word path and the calibrated tables
// no handshake, every signal valid every cycle
interface dtc_lut_if import fod_pkg::*; ();

	// address side
	seg_idx_t                seg_idx;
	logic                    quant;

	// table entries for the current address
	logic signed [LUT_W-1:0] gain_b;
	logic signed [LUT_W-1:0] offset_c;
	logic signed [LUT_W-1:0] offset_d;

	// word path drives the address and reads the entries
	modport word_calc (
		output seg_idx,
		output quant,
		input  gain_b,
		input  offset_c,
		input  offset_d
	);

	// tables return the entries combinationally
	modport lut (
		input  seg_idx,
		input  quant,
		output gain_b,
		output offset_c,
		output offset_d
	);

endinterface

//--- fod_pkg.sv
package fod_pkg;

	// ------------------------------
	// word widths
	// ------------------------------

	// integer bits of the frequency control word
	localparam int WI = 6;

	// fractional bits of the FCW and of the DSM phase
	localparam int WF = 16;

	// full FCW width
	localparam int FCW_W = WI + WF;

	// delay-line control word width
	localparam int DCW_W = 10;

	// table entry, signed fixed point with WF fraction bits
	localparam int LUT_W = DCW_W + WF + 1;

	// segments in the gain and offset tables
	localparam int N_SEG = 8;

	// ------------------------------
	// reset values
	// ------------------------------

	// divider modulus after reset
	localparam logic [WI-1:0] MMD_RESET = WI'(4);

	// ------------------------------
	// shared types
	// ------------------------------

	// DSM residual phase, one word read two ways
	// frac for the plain fraction in 0..1 (retimer off)
	// rt splits off the half-cycle quant bit (retimer on)
	typedef union packed {
		logic [WF-1:0] frac;
		struct packed {
			logic          quant;
			logic [WF-2:0] rem;
		} rt;
	} dsm_phe_u;

	// segment index into the gain and offset tables
	typedef logic [2:0] seg_idx_t;

endpackage
